/* build.f */
rtl/cache_pkg.sv
rtl/dcache_lookup.sv
rtl/dcache_line_store.sv
rtl/dcache_miss_ctrl.sv
rtl/dcache_response.sv
rtl/dcache.sv
sim/tb_clock.sv
sim/cbus_memory.sv
sim/dcache_assertions.sv
sim/dcache_tb.sv

/* rtl/cache_pkg.sv */
package cache_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [63:0] word_t;
    typedef logic [7:0] strobe_t;
    typedef logic [7:0] len_t;

    // zero strobe means a read
    typedef struct packed {
        logic    valid;
        addr_t   addr;
        strobe_t strobe;
        word_t   data;
    } dbus_req_t;

    typedef struct packed {
        logic  data_ok;
        word_t data;
    } dbus_resp_t;

    // len is beats minus one
    typedef struct packed {
        logic    valid;
        logic    is_write;
        addr_t   addr;
        len_t    len;
        strobe_t strobe;
        word_t   data;
    } cbus_req_t;

    typedef struct packed {
        logic  ready;
        logic  last;
        word_t data;
    } cbus_resp_t;

    typedef enum logic [1:0] {
        READY,
        FLUSH,
        FETCH,
        UNCACHED
    } ctrl_state_t;

endpackage

/* rtl/dcache.sv */
`timescale 1ns/1ns

module dcache #(
    parameter int WORDS_PER_LINE = 4,
    parameter int SET_NUM = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  cache_pkg::dbus_req_t  dreq,
    output cache_pkg::dbus_resp_t dresp,
    output cache_pkg::cbus_req_t  creq,
    input  cache_pkg::cbus_resp_t cresp
);

    localparam int OFF_BITS = $clog2(WORDS_PER_LINE);
    localparam int IDX_BITS = $clog2(SET_NUM);
    localparam int TAG_BITS = 29 - OFF_BITS - IDX_BITS;

    logic [1:0][TAG_BITS-1:0] way_tags;
    logic [1:0]               way_valid;
    logic [1:0]               way_dirty;
    logic                     hit;
    logic                     hit_way;
    logic                     victim_way;
    logic                     victim_dirty;
    logic                     lru_touch;
    logic                     hit_done;
    cache_pkg::ctrl_state_t   state;
    logic [OFF_BITS-1:0]      beat;
    logic                     way;
    logic                     data_we;
    cache_pkg::strobe_t       data_strobe;
    cache_pkg::word_t         wdata;
    logic                     tag_we;
    logic                     set_dirty;
    cache_pkg::word_t         rdata;
    logic [IDX_BITS-1:0]      set_index;
    logic [TAG_BITS-1:0]      new_tag;
    logic [TAG_BITS-1:0]      victim_tag;

    assign set_index = dreq.addr[3 + OFF_BITS +: IDX_BITS];
    assign new_tag = dreq.addr[31 -: TAG_BITS];
    // way holds the saved victim while flushing
    assign victim_tag = way_tags[way];

    dcache_lookup #(
        .WORDS_PER_LINE(WORDS_PER_LINE),
        .SET_NUM(SET_NUM)
    ) u_lookup (
        .clk(clk),
        .reset(reset),
        .addr(dreq.addr),
        .way_tags(way_tags),
        .way_valid(way_valid),
        .way_dirty(way_dirty),
        .lru_touch(lru_touch),
        .hit(hit),
        .hit_way(hit_way),
        .victim_way(victim_way),
        .victim_dirty(victim_dirty)
    );

    dcache_line_store #(
        .WORDS_PER_LINE(WORDS_PER_LINE),
        .SET_NUM(SET_NUM)
    ) u_store (
        .clk(clk),
        .reset(reset),
        .set_index(set_index),
        .word_index(beat),
        .way(way),
        .data_we(data_we),
        .data_strobe(data_strobe),
        .wdata(wdata),
        .tag_we(tag_we),
        .new_tag(new_tag),
        .set_dirty(set_dirty),
        .rdata(rdata),
        .way_tags(way_tags),
        .way_valid(way_valid),
        .way_dirty(way_dirty)
    );

    dcache_miss_ctrl #(
        .WORDS_PER_LINE(WORDS_PER_LINE),
        .SET_NUM(SET_NUM)
    ) u_ctrl (
        .clk(clk),
        .reset(reset),
        .dreq(dreq),
        .cresp(cresp),
        .hit(hit),
        .hit_way(hit_way),
        .victim_way(victim_way),
        .victim_dirty(victim_dirty),
        .state(state),
        .beat(beat),
        .way(way),
        .data_we(data_we),
        .data_strobe(data_strobe),
        .wdata(wdata),
        .tag_we(tag_we),
        .set_dirty(set_dirty),
        .lru_touch(lru_touch),
        .hit_done(hit_done)
    );

    dcache_response #(
        .WORDS_PER_LINE(WORDS_PER_LINE),
        .SET_NUM(SET_NUM)
    ) u_response (
        .state(state),
        .dreq(dreq),
        .cresp(cresp),
        .rdata(rdata),
        .hit_done(hit_done),
        .victim_tag(victim_tag),
        .dresp(dresp),
        .creq(creq)
    );

endmodule

/* rtl/dcache_line_store.sv */
`timescale 1ns/1ns

module dcache_line_store #(
    parameter int WORDS_PER_LINE = 4,
    parameter int SET_NUM = 8,
    localparam int OFF_BITS = $clog2(WORDS_PER_LINE),
    localparam int IDX_BITS = $clog2(SET_NUM),
    localparam int TAG_BITS = 29 - OFF_BITS - IDX_BITS
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [IDX_BITS-1:0]      set_index,
    input  logic [OFF_BITS-1:0]      word_index,
    input  logic                     way,
    input  logic                     data_we,
    input  cache_pkg::strobe_t       data_strobe,
    input  cache_pkg::word_t         wdata,
    input  logic                     tag_we,
    input  logic [TAG_BITS-1:0]      new_tag,
    input  logic                     set_dirty,
    output cache_pkg::word_t         rdata,
    output logic [1:0][TAG_BITS-1:0] way_tags,
    output logic [1:0]               way_valid,
    output logic [1:0]               way_dirty
);

    cache_pkg::word_t    data_mem [2][SET_NUM][WORDS_PER_LINE];
    logic [TAG_BITS-1:0] tag_mem [2][SET_NUM];
    logic [1:0][SET_NUM-1:0] valid;
    logic [1:0][SET_NUM-1:0] dirty;

    // byte lane writes
    always_ff @(posedge clk) begin
        if (data_we) begin
            for (int b = 0; b < 8; b++) begin
                if (data_strobe[b]) begin
                    data_mem[way][set_index][word_index][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
        if (tag_we) begin
            tag_mem[way][set_index] <= new_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            valid <= '0;
            dirty <= '0;
        end else if (tag_we) begin
            valid[way][set_index] <= 1'b1;
            dirty[way][set_index] <= 1'b0;
        end else if (set_dirty) begin
            dirty[way][set_index] <= 1'b1;
        end
    end

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_tags[w] = tag_mem[w][set_index];
            way_valid[w] = valid[w][set_index];
            way_dirty[w] = dirty[w][set_index];
        end
    end

    assign rdata = data_mem[way][set_index][word_index];

endmodule

/* rtl/dcache_lookup.sv */
`timescale 1ns/1ns

module dcache_lookup #(
    parameter int WORDS_PER_LINE = 4,
    parameter int SET_NUM = 8,
    localparam int OFF_BITS = $clog2(WORDS_PER_LINE),
    localparam int IDX_BITS = $clog2(SET_NUM),
    localparam int TAG_BITS = 29 - OFF_BITS - IDX_BITS
) (
    input  logic                     clk,
    input  logic                     reset,
    input  cache_pkg::addr_t         addr,
    input  logic [1:0][TAG_BITS-1:0] way_tags,
    input  logic [1:0]               way_valid,
    input  logic [1:0]               way_dirty,
    input  logic                     lru_touch,
    output logic                     hit,
    output logic                     hit_way,
    output logic                     victim_way,
    output logic                     victim_dirty
);

    localparam int IDX_LO = 3 + OFF_BITS;

    logic [IDX_BITS-1:0] set_index;
    logic [TAG_BITS-1:0] req_tag;
    logic [1:0]          way_match;
    // one bit per set, names the way to replace next
    logic [SET_NUM-1:0]  lru;

    assign set_index = addr[IDX_LO +: IDX_BITS];
    assign req_tag = addr[31 -: TAG_BITS];

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_match[w] = way_valid[w] && (way_tags[w] == req_tag);
        end
    end

    assign hit = |way_match;
    assign hit_way = way_match[1];

    // empty way first, then the least recently used one
    always_comb begin
        if (!way_valid[0]) begin
            victim_way = 1'b0;
        end else if (!way_valid[1]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru[set_index];
        end
    end

    assign victim_dirty = way_valid[victim_way] && way_dirty[victim_way];

    always_ff @(posedge clk) begin
        if (!reset) begin
            lru <= '0;
        end else if (lru_touch) begin
            lru[set_index] <= ~hit_way;
        end
    end

endmodule

/* rtl/dcache_miss_ctrl.sv */
`timescale 1ns/1ns

module dcache_miss_ctrl #(
    parameter int WORDS_PER_LINE = 4,
    parameter int SET_NUM = 8,
    localparam int OFF_BITS = $clog2(WORDS_PER_LINE),
    localparam int IDX_BITS = $clog2(SET_NUM)
) (
    input  logic                   clk,
    input  logic                   reset,
    input  cache_pkg::dbus_req_t   dreq,
    input  cache_pkg::cbus_resp_t  cresp,
    input  logic                   hit,
    input  logic                   hit_way,
    input  logic                   victim_way,
    input  logic                   victim_dirty,
    output cache_pkg::ctrl_state_t state,
    output logic [OFF_BITS-1:0]    beat,
    output logic                   way,
    output logic                   data_we,
    output cache_pkg::strobe_t     data_strobe,
    output cache_pkg::word_t       wdata,
    output logic                   tag_we,
    output logic                   set_dirty,
    output logic                   lru_touch,
    output logic                   hit_done
);

    logic [OFF_BITS-1:0] count;
    logic                saved_way;
    logic                in_burst;
    logic                write_hit;

    always_ff @(posedge clk) begin
        if (!reset) begin
            state <= cache_pkg::READY;
            count <= '0;
            saved_way <= 1'b0;
            hit_done <= 1'b0;
        end else begin
            hit_done <= 1'b0;
            unique case (state)
                cache_pkg::READY: begin
                    // request is still up during the hit_done cycle
                    if (dreq.valid && !hit_done) begin
                        if (!dreq.addr[31]) begin
                            state <= cache_pkg::UNCACHED;
                        end else if (hit) begin
                            hit_done <= 1'b1;
                        end else begin
                            saved_way <= victim_way;
                            count <= '0;
                            state <= victim_dirty ? cache_pkg::FLUSH : cache_pkg::FETCH;
                        end
                    end
                end
                cache_pkg::FLUSH: begin
                    if (cresp.ready) begin
                        count <= count + 1'b1;
                        if (cresp.last) begin
                            count <= '0;
                            state <= cache_pkg::FETCH;
                        end
                    end
                end
                cache_pkg::FETCH: begin
                    if (cresp.ready) begin
                        count <= count + 1'b1;
                        if (cresp.last) begin
                            state <= cache_pkg::READY;
                        end
                    end
                end
                cache_pkg::UNCACHED: begin
                    if (cresp.ready && cresp.last) begin
                        state <= cache_pkg::READY;
                    end
                end
                default: state <= cache_pkg::READY;
            endcase
        end
    end

    assign in_burst = (state == cache_pkg::FLUSH) || (state == cache_pkg::FETCH);
    assign write_hit = hit_done && (|dreq.strobe);

    // burst counter during line moves, request word otherwise
    assign beat = in_burst ? count : dreq.addr[3 +: OFF_BITS];
    assign way = in_burst ? saved_way : hit_way;

    assign data_we = ((state == cache_pkg::FETCH) && cresp.ready) || write_hit;
    assign data_strobe = (state == cache_pkg::FETCH) ? '1 : dreq.strobe;
    assign wdata = (state == cache_pkg::FETCH) ? cresp.data : dreq.data;
    assign tag_we = (state == cache_pkg::FETCH) && cresp.ready && cresp.last;
    assign set_dirty = write_hit;
    assign lru_touch = hit_done;

endmodule

/* rtl/dcache_response.sv */
`timescale 1ns/1ns

module dcache_response #(
    parameter int WORDS_PER_LINE = 4,
    parameter int SET_NUM = 8,
    localparam int OFF_BITS = $clog2(WORDS_PER_LINE),
    localparam int IDX_BITS = $clog2(SET_NUM),
    localparam int TAG_BITS = 29 - OFF_BITS - IDX_BITS
) (
    input  cache_pkg::ctrl_state_t state,
    input  cache_pkg::dbus_req_t   dreq,
    input  cache_pkg::cbus_resp_t  cresp,
    input  cache_pkg::word_t       rdata,
    input  logic                   hit_done,
    input  logic [TAG_BITS-1:0]    victim_tag,
    output cache_pkg::dbus_resp_t  dresp,
    output cache_pkg::cbus_req_t   creq
);

    localparam int LINE_LO = 3 + OFF_BITS;

    logic                uncached;
    logic [IDX_BITS-1:0] set_index;

    assign uncached = state == cache_pkg::UNCACHED;
    assign set_index = dreq.addr[LINE_LO +: IDX_BITS];

    assign dresp.data_ok = uncached ? (cresp.ready && cresp.last) : hit_done;
    assign dresp.data = uncached ? cresp.data : rdata;

    always_comb begin
        creq.valid = state != cache_pkg::READY;
        creq.is_write = (state == cache_pkg::FLUSH) || (uncached && (|dreq.strobe));
        creq.len = uncached ? '0 : cache_pkg::len_t'(WORDS_PER_LINE - 1);
        creq.strobe = uncached ? dreq.strobe : '1;
        creq.data = uncached ? dreq.data : rdata;
        unique case (state)
            // write back goes to the victim's own line
            cache_pkg::FLUSH: creq.addr = {victim_tag, set_index, {LINE_LO{1'b0}}};
            cache_pkg::UNCACHED: creq.addr = dreq.addr;
            default: creq.addr = {dreq.addr[31:LINE_LO], {LINE_LO{1'b0}}};
        endcase
    end

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module dcache_tb -f build.f -o dcache_sim

status=0
./obj_dir/dcache_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Done: errors found" sim.log || [ "$status" -ne 0 ]; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

/* sim/cbus_memory.sv */
`timescale 1ns/1ns

module cbus_memory (
    input  logic                  clk,
    input  logic                  reset,
    input  cache_pkg::cbus_req_t  creq,
    output cache_pkg::cbus_resp_t cresp
);

    // only written words are stored
    cache_pkg::word_t mem [cache_pkg::addr_t];
    logic [7:0]       count;
    int unsigned      stall;
    cache_pkg::addr_t beat_addr;

    function automatic cache_pkg::word_t merge_lanes(input cache_pkg::word_t old_word,
                                                     input cache_pkg::word_t new_word,
                                                     input cache_pkg::strobe_t strobe);
        cache_pkg::word_t result;
        result = old_word;
        for (int b = 0; b < 8; b++) begin
            if (strobe[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    always_comb begin
        beat_addr = {creq.addr[31:3], 3'b000} + {21'b0, count, 3'b000};
        cresp.ready = creq.valid && (stall == 0);
        cresp.last = cresp.ready && (count == creq.len);
        // unwritten words read as address and its inverse
        if (mem.exists(beat_addr)) begin
            cresp.data = mem[beat_addr];
        end else begin
            cresp.data = {~beat_addr, beat_addr};
        end
    end

    initial begin
        void'($urandom(32'h28a275d5));
        forever begin
            @(posedge clk);
            if (!reset) begin
                count <= '0;
                stall <= 0;
            end else if (creq.valid) begin
                if (stall != 0) begin
                    stall <= stall - 1;
                end else begin
                    // a beat moves in this cycle
                    if (creq.is_write) begin
                        mem[beat_addr] = merge_lanes(cresp.data, creq.data, creq.strobe);
                    end
                    count <= (count == creq.len) ? 8'd0 : count + 8'd1;
                    stall <= $urandom % 4;
                end
            end
        end
    end

endmodule

/* sim/dcache_assertions.sv */
`timescale 1ns/1ns

module dcache_assertions (
    input logic                  clk,
    input logic                  reset,
    input cache_pkg::cbus_req_t  creq,
    input cache_pkg::cbus_resp_t cresp,
    input cache_pkg::dbus_resp_t dresp
);

    creq_idle_in_reset: assert property (@(posedge clk) !reset |=> !creq.valid)
        else $error("creq.valid is high while reset is held");

    // request must hold while memory stalls
    creq_stable_on_stall: assert property (@(posedge clk) disable iff (!reset)
        creq.valid && !cresp.ready |=> $stable(creq))
        else $error("creq changed while waiting for cresp.ready");

    data_ok_single_cycle: assert property (@(posedge clk) disable iff (!reset)
        dresp.data_ok |=> !dresp.data_ok)
        else $error("dresp.data_ok stayed high for two cycles");

endmodule

bind dcache dcache_assertions u_assertions (
    .clk(clk),
    .reset(reset),
    .creq(creq),
    .cresp(cresp),
    .dresp(dresp)
);

/* sim/dcache_tb.sv */
`timescale 1ns/1ns

module dcache_tb;

    localparam int WORDS_PER_LINE = 4;
    localparam int SET_NUM = 8;
    localparam int CYCLES_PER_TEST = 300;

    logic                  clk;
    logic                  reset;
    cache_pkg::dbus_req_t  dreq;
    cache_pkg::dbus_resp_t dresp;
    cache_pkg::cbus_req_t  creq;
    cache_pkg::cbus_resp_t cresp;

    string              test_name [$];
    cache_pkg::addr_t   test_addr [$];
    cache_pkg::strobe_t test_strobe [$];
    cache_pkg::word_t   test_wdata [$];
    cache_pkg::word_t   test_expect [$];
    logic               test_hit [$];

    int cycle_limit = 0;
    int cycle_count = 0;

    tb_clock #(.PERIOD(8), .RESET_CYCLES(10)) u_clock (.clk(clk), .reset(reset));

    dcache #(
        .WORDS_PER_LINE(WORDS_PER_LINE),
        .SET_NUM(SET_NUM)
    ) dut (
        .clk(clk),
        .reset(reset),
        .dreq(dreq),
        .dresp(dresp),
        .creq(creq),
        .cresp(cresp)
    );

    cbus_memory u_memory (.clk(clk), .reset(reset), .creq(creq), .cresp(cresp));

    task automatic load_tests();
        int                 fd;
        string              line;
        string              name;
        cache_pkg::addr_t   addr;
        cache_pkg::strobe_t strobe;
        cache_pkg::word_t   wdata;
        cache_pkg::word_t   expected;
        int                 hit;
        fd = $fopen("sim/dcache_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/dcache_tests.txt");
            $display("Done: errors found");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) != 0) begin
                // comment lines fail to parse and drop out here
                if ($sscanf(line, "%s %h %h %h %h %d", name, addr, strobe, wdata,
                            expected, hit) == 6) begin
                    test_name.push_back(name);
                    test_addr.push_back(addr);
                    test_strobe.push_back(strobe);
                    test_wdata.push_back(wdata);
                    test_expect.push_back(expected);
                    test_hit.push_back(hit != 0);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic run_request(input cache_pkg::addr_t addr, input cache_pkg::strobe_t strobe,
                               input cache_pkg::word_t wdata, output cache_pkg::word_t rdata,
                               output logic saw_creq);
        logic done;
        done = 1'b0;
        rdata = '0;
        saw_creq = 1'b0;
        dreq.valid = 1'b1;
        dreq.addr = addr;
        dreq.strobe = strobe;
        dreq.data = wdata;
        while (!done) begin
            @(negedge clk);
            if (creq.valid) begin
                saw_creq = 1'b1;
            end
            if (dresp.data_ok) begin
                rdata = dresp.data;
                done = 1'b1;
            end
        end
        @(posedge clk);
        #1;
    endtask

    task automatic check_word(input string name, input cache_pkg::word_t expected,
                              input cache_pkg::word_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: read data expected %h, actual %h", name, expected, actual);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    task automatic check_hit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAILED %s: hit flag expected %0b, actual %0b", name, expected, actual);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the test run did not finish within %0d cycles", cycle_limit);
            $display("Done: errors found");
            $fatal(1);
        end
    end

    initial begin
        cache_pkg::word_t read_data;
        logic             saw_creq;
        dreq = '0;
        load_tests();
        cycle_limit = CYCLES_PER_TEST * test_name.size() + 20;
        if (test_name.size() == 0) begin
            $display("no tests found in sim/dcache_tests.txt");
            $display("Done: errors found");
            $fatal(1);
        end
        wait (reset === 1'b1);
        @(posedge clk);
        #1;
        for (int i = 0; i < test_name.size(); i++) begin
            run_request(test_addr[i], test_strobe[i], test_wdata[i], read_data, saw_creq);
            // writes return no data worth checking
            if (test_strobe[i] == '0) begin
                check_word(test_name[i], test_expect[i], read_data);
            end
            check_hit(test_name[i], test_hit[i], !saw_creq);
        end
        dreq = '0;
        repeat (4) @(posedge clk);
        $display("Done: no errors");
        $finish;
    end

endmodule

/* sim/dcache_tests.txt */
# name address strobe write_data expected_read hit
# strobe 00 is a read, hex columns, hit 1 means no memory request expected
rd_miss_first      80000000 00 0000000000000000 7fffffff80000000 0
rd_hit_same_line   80000018 00 0000000000000000 7fffffe780000018 1
wr_low_lanes       80000008 0f 1122334455667788 0000000000000000 1
rd_low_lanes       80000008 00 0000000000000000 7ffffff755667788 1
wr_high_lanes      80000010 c0 aabbccddeeff0011 0000000000000000 1
rd_high_lanes      80000010 00 0000000000000000 aabbffef80000010 1
ev_wr_a            80000020 ff a0a0a0a0a0a0a0a0 0000000000000000 0
ev_wr_b            80000128 ff b1b1b1b1b1b1b1b1 0000000000000000 0
ev_rd_c            80000230 00 0000000000000000 7ffffdcf80000230 0
ev_rd_a_back       80000020 00 0000000000000000 a0a0a0a0a0a0a0a0 0
ev_rd_a_other      80000028 00 0000000000000000 7fffffd780000028 1
ev_rd_b_back       80000128 00 0000000000000000 b1b1b1b1b1b1b1b1 0
lru_a_miss         80000040 00 0000000000000000 7fffffbf80000040 0
lru_b_miss         80000140 00 0000000000000000 7ffffebf80000140 0
lru_a_touch        80000040 00 0000000000000000 7fffffbf80000040 1
lru_c_evicts_b     80000240 00 0000000000000000 7ffffdbf80000240 0
lru_a_kept         80000040 00 0000000000000000 7fffffbf80000040 1
lru_b_gone         80000140 00 0000000000000000 7ffffebf80000140 0
unc_rd             00000008 00 0000000000000000 fffffff700000008 0
unc_wr             00000008 ff 0123456789abcdef 0000000000000000 0
unc_rd_back        00000008 00 0000000000000000 0123456789abcdef 0
unc_wr_part        00000010 03 000000000000cafe 0000000000000000 0
unc_rd_part        00000010 00 0000000000000000 ffffffef0000cafe 0
alias_low_lanes    80000008 00 0000000000000000 7ffffff755667788 1
alias_high_lanes   80000010 00 0000000000000000 aabbffef80000010 1

/* sim/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD = 8,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // active low, released just after an edge
    initial begin
        reset = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b1;
    end

endmodule
